/* list.f */
rtl/rv_pkg.sv
rtl/rf_if.sv
rtl/core_fsm.sv
rtl/pc_unit.sv
rtl/insn_decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/mem_writeback.sv
rtl/rv_core.sv
testbench/tb_rv_core.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= list.f
TB_TOP     ?= tb_rv_core
RTL_TOP    ?= rv_core
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "failure reported, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "sim passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

  localparam int    NUM_PROGS  = 3;
  localparam int    NUM_INSN   = 200;
  localparam int    IMEM_WORDS = 256;
  localparam int    DMEM_WORDS = 512;
  localparam int    MAX_CYCLES = NUM_PROGS * (3 * IMEM_WORDS + 50);
  localparam word_t ECALL      = 32'h0000_0073;

  logic       clk;
  logic       rst;
  logic       imem_rd;
  word_t      imem_addr;
  word_t      imem_data;
  logic       dmem_rd;
  word_t      dmem_addr;
  word_t      dmem_wdata;
  logic [3:0] dmem_we;
  word_t      dmem_rdata;
  logic       halt;
  word_t      instret;

  // memories seen by the DUT
  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];

  // reference model state
  word_t       mref  [DMEM_WORDS];
  word_t       mregs [NUM_REGS];
  word_t       m_pc;
  int unsigned m_count;
  word_t       last_instret;
  logic        halt_seen;
  logic        store_seen;
  word_t       store_mask;

  // effects the model expects from the instruction in flight
  logic       p_halt;
  logic       p_we;
  logic       p_load;
  logic       p_store;
  reg_addr_t  p_rd;
  word_t      p_val;
  word_t      p_next;
  word_t      p_addr;
  word_t      p_data;
  logic [3:0] p_strb;

  int seed    = 97;
  int errors  = 0;
  int n_fetch = 0;
  int n_store = 0;
  int n_load  = 0;
  int cycles  = 0;

  rv_core i_rv_core (
    .clk          (clk),
    .rst          (rst),
    .imem_rd_o    (imem_rd),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_rd_o    (dmem_rd),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_we_o    (dmem_we),
    .dmem_rdata_i (dmem_rdata),
    .halt_o       (halt),
    .instret_o    (instret)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // memory model with one cycle of read latency
  initial begin
    imem_data  = '0;
    dmem_rdata = '0;
    forever begin
      @(posedge clk);
      if (imem_rd) begin
        imem_data <= imem[imem_addr[9:2]];
      end
      if (dmem_rd) begin
        dmem_rdata <= dmem[dmem_addr[10:2]];
      end
      for (int b = 0; b < 4; b++) begin
        if (dmem_we[b]) begin
          dmem[dmem_addr[10:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  function automatic int unsigned pick(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // size-aligned offset into the data window 0x400..0x7ff
  function automatic logic [11:0] data_offset(logic [2:0] f3);
    logic [11:0] off;
    off = 12'h400 | 12'(pick(1024));
    if (f3[1:0] == 2'b01) begin
      off[0] = 1'b0;
    end else if (f3[1:0] == 2'b10) begin
      off[1:0] = 2'b00;
    end
    return off;
  endfunction

  function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'd0, $signed(x) < $signed(y)};
      3'd3:    return {31'd0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic note_mismatch(string name, word_t got, word_t exp);
    $display("mismatch at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    errors++;
  endtask

  task automatic fail_check(string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic gen_program();
    int unsigned span;
    int unsigned jump;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = ECALL;
    end
    for (int j = 0; j < DMEM_WORDS; j++) begin
      dmem[j] = $random(seed);
    end
    for (int i = 0; i < NUM_INSN - 1; i++) begin
      rd   = reg_addr_t'(pick(32));
      rs1  = reg_addr_t'(pick(32));
      rs2  = reg_addr_t'(pick(32));
      f3   = 3'(pick(8));
      f7   = (f3 == F3_ADD || f3 == F3_SR) && pick(2) == 1 ? ALT_FUNCT7 : 7'd0;
      // forward targets stay at or before the closing ecall
      span = NUM_INSN - 1 - i;
      if (span > 16) begin
        span = 16;
      end
      jump = 4 * (1 + pick(span));
      case (pick(13))
        0, 1, 2: imem[i] = enc_r(f7, rs2, rs1, f3, rd, OP_OP);
        3, 4: begin
          if (f3 == F3_SLL) begin
            imm = {7'd0, rs2};
          end else if (f3 == F3_SR) begin
            imm = {f7, rs2};
          end else begin
            imm = 12'(pick(4096));
          end
          imem[i] = enc_i(imm, rs1, f3, rd, OP_IMM);
        end
        5: imem[i] = {20'(pick(1 << 20)), rd, OP_LUI};
        6: imem[i] = {20'(pick(1 << 20)), rd, OP_AUIPC};
        7: begin
          case (pick(5))
            0:       f3 = F3_B;
            1:       f3 = F3_H;
            2:       f3 = F3_W;
            3:       f3 = F3_BU;
            default: f3 = F3_HU;
          endcase
          imem[i] = enc_i(data_offset(f3), 5'd0, f3, rd, OP_LOAD);
        end
        8, 9: begin
          f3      = 3'(pick(3));
          imem[i] = enc_s(data_offset(f3), rs2, f3);
        end
        10: begin
          f3 = 3'(pick(6));
          if (f3 > 3'd1) begin
            f3 = f3 + 3'd2;
          end
          imem[i] = enc_b(13'(jump), rs2, rs1, f3);
        end
        11:      imem[i] = enc_j(21'(jump), rd);
        default: imem[i] = enc_i(12'(4 * i + jump), 5'd0, 3'd0, rd, OP_JALR);
      endcase
    end
  endtask

  // work out what the instruction at the model pc should do
  task automatic predict();
    word_t      insn;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      ea;
    word_t      lane;
    logic [2:0] f3;
    logic       taken;
    insn    = imem[m_pc[9:2]];
    f3      = insn[14:12];
    rs1_val = mregs[insn[19:15]];
    rs2_val = mregs[insn[24:20]];
    imm_i   = {{20{insn[31]}}, insn[31:20]};
    imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j   = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_u   = {insn[31:12], 12'd0};
    taken   = 1'b0;
    p_halt  = 1'b0;
    p_we    = 1'b0;
    p_load  = 1'b0;
    p_store = 1'b0;
    p_rd    = insn[11:7];
    p_val   = '0;
    p_next  = m_pc + 32'd4;
    p_addr  = '0;
    p_data  = '0;
    p_strb  = 4'b0000;
    case (insn[6:0])
      OP_OP: begin
        p_we  = 1'b1;
        p_val = alu_model(f3, insn[30], rs1_val, rs2_val);
      end
      OP_IMM: begin
        p_we  = 1'b1;
        p_val = alu_model(f3, insn[30] && f3 == F3_SR, rs1_val, imm_i);
      end
      OP_LUI: begin
        p_we  = 1'b1;
        p_val = imm_u;
      end
      OP_AUIPC: begin
        p_we  = 1'b1;
        p_val = m_pc + imm_u;
      end
      OP_JAL: begin
        p_we   = 1'b1;
        p_val  = m_pc + 32'd4;
        p_next = m_pc + imm_j;
      end
      OP_JALR: begin
        p_we   = 1'b1;
        p_val  = m_pc + 32'd4;
        p_next = (rs1_val + imm_i) & ~32'd1;
      end
      OP_BRANCH: begin
        case (f3)
          F3_BEQ:  taken = (rs1_val == rs2_val);
          F3_BNE:  taken = (rs1_val != rs2_val);
          F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
          F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
          F3_BLTU: taken = (rs1_val < rs2_val);
          default: taken = (rs1_val >= rs2_val);
        endcase
        if (taken) begin
          p_next = m_pc + imm_b;
        end
      end
      OP_LOAD: begin
        ea     = rs1_val + imm_i;
        lane   = mref[ea[10:2]] >> {ea[1:0], 3'b000};
        p_load = 1'b1;
        p_we   = 1'b1;
        p_addr = ea;
        case (f3)
          F3_B:    p_val = {{24{lane[7]}}, lane[7:0]};
          F3_BU:   p_val = {24'd0, lane[7:0]};
          F3_H:    p_val = {{16{lane[15]}}, lane[15:0]};
          F3_HU:   p_val = {16'd0, lane[15:0]};
          default: p_val = lane;
        endcase
      end
      OP_STORE: begin
        ea      = rs1_val + imm_s;
        p_store = 1'b1;
        p_addr  = ea;
        p_data  = rs2_val << {ea[1:0], 3'b000};
        case (f3)
          F3_B:    p_strb = 4'b0001 << ea[1:0];
          F3_H:    p_strb = 4'b0011 << ea[1:0];
          default: p_strb = 4'b1111;
        endcase
      end
      default: p_halt = 1'b1;
    endcase
  endtask

  task automatic commit();
    if (p_we && p_rd != 5'd0) begin
      mregs[p_rd] = p_val;
    end
    for (int b = 0; b < 4; b++) begin
      if (p_store && p_strb[b]) begin
        mref[p_addr[10:2]][8*b +: 8] = p_data[8*b +: 8];
      end
    end
    m_pc = p_next;
    // ecall and illegal encodings never count as retired
    if (!p_halt) begin
      m_count = m_count + 1;
    end
  endtask

  // follows the DUT ports and steps the model on every retirement
  always @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        mregs[r] = '0;
      end
      for (int j = 0; j < DMEM_WORDS; j++) begin
        mref[j] = dmem[j];
      end
      m_pc         = '0;
      m_count      = 0;
      last_instret = '0;
      halt_seen    = 1'b0;
      store_seen   = 1'b0;
      p_halt       = 1'b0;
      p_load       = 1'b0;
      p_store      = 1'b0;
    end else begin
      if (instret !== last_instret) begin
        if (instret !== word_t'(m_count) + 32'd1) begin
          note_mismatch("instret_o", instret, word_t'(m_count) + 32'd1);
        end
        if (p_store && !store_seen) begin
          fail_check("a store retired without driving its byte strobes");
        end
        commit();
        last_instret = instret;
      end
      if (imem_rd) begin
        if (halt_seen) begin
          fail_check("instruction fetch after the core halted");
        end
        if (imem_addr !== m_pc) begin
          note_mismatch("imem_addr_o", imem_addr, m_pc);
        end
        predict();
        store_seen = 1'b0;
        n_fetch++;
      end
      if (dmem_we !== 4'b0000) begin
        store_seen = 1'b1;
        if (!p_store || halt_seen) begin
          fail_check("store issued where the program has none");
        end else begin
          store_mask = {{8{p_strb[3]}}, {8{p_strb[2]}}, {8{p_strb[1]}}, {8{p_strb[0]}}};
          if (dmem_addr !== {p_addr[31:2], 2'b00}) begin
            note_mismatch("dmem_addr_o", dmem_addr, {p_addr[31:2], 2'b00});
          end
          if (dmem_we !== p_strb) begin
            note_mismatch("dmem_we_o", {28'd0, dmem_we}, {28'd0, p_strb});
          end
          if ((dmem_wdata & store_mask) !== (p_data & store_mask)) begin
            note_mismatch("dmem_wdata_o", dmem_wdata & store_mask, p_data & store_mask);
          end
          n_store++;
        end
      end
      if (dmem_rd) begin
        if (!p_load || halt_seen) begin
          fail_check("data read issued where the program has no load");
        end else if (dmem_addr !== {p_addr[31:2], 2'b00}) begin
          note_mismatch("dmem_addr_o", dmem_addr, {p_addr[31:2], 2'b00});
        end
        n_load++;
      end
      if (halt && !halt_seen) begin
        halt_seen = 1'b1;
        if (!p_halt) begin
          fail_check("core halted on an instruction other than ecall");
        end
        if (instret !== word_t'(m_count)) begin
          note_mismatch("instret_o", instret, word_t'(m_count));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d errors, the core never reached ecall",
               cycles, errors);
      $display("sim failed");
      $finish;
    end
  end

  task automatic run_program();
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    gen_program();
    @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (halt !== 1'b0) begin
      note_mismatch("halt_o", {31'd0, halt}, 32'd0);
    end
    if (instret !== 32'd0) begin
      note_mismatch("instret_o", instret, 32'd0);
    end
    if (dmem_we !== 4'b0000) begin
      note_mismatch("dmem_we_o", {28'd0, dmem_we}, 32'd0);
    end
    if (dmem_rd !== 1'b0) begin
      note_mismatch("dmem_rd_o", {31'd0, dmem_rd}, 32'd0);
    end
    if (imem_rd !== 1'b1 || imem_addr !== 32'd0) begin
      fail_check("first cycle after reset is not a fetch from address zero");
    end
    while (!halt_seen) begin
      @(posedge clk);
    end
    // watch for stray accesses after the halt
    repeat (10) @(posedge clk);
  endtask

  initial begin
    rst = 1'b1;
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program();
    end
    $display("programs %0d, fetches %0d, stores %0d, loads %0d, errors %0d",
             NUM_PROGS, n_fetch, n_store, n_load, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  output logic       imem_rd_o,
  output word_t      imem_addr_o,
  input  word_t      imem_data_i,
  output logic       dmem_rd_o,
  output word_t      dmem_addr_o,
  output word_t      dmem_wdata_o,
  output logic [3:0] dmem_we_o,
  input  word_t      dmem_rdata_i,
  output logic       halt_o,
  output word_t      instret_o
);

  decoded_t dec;
  word_t    pc;
  word_t    alu_result;
  logic     store_en;
  logic     pc_en;

  rf_if rf_bus ();

  assign imem_addr_o = pc;

  core_fsm i_core_fsm (
    .clk        (clk),
    .rst        (rst),
    .dec_i      (dec),
    .rf         (rf_bus.ctl),
    .imem_rd_o  (imem_rd_o),
    .dmem_rd_o  (dmem_rd_o),
    .store_en_o (store_en),
    .pc_en_o    (pc_en),
    .halt_o     (halt_o),
    .instret_o  (instret_o)
  );

  pc_unit i_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .pc_en_i      (pc_en),
    .dec_i        (dec),
    .rf           (rf_bus.src),
    .alu_result_i (alu_result),
    .pc_o         (pc)
  );

  insn_decoder i_insn_decoder (
    .insn_i (imem_data_i),
    .dec_o  (dec),
    .rf     (rf_bus.dec)
  );

  alu i_alu (
    .dec_i    (dec),
    .pc_i     (pc),
    .rf       (rf_bus.src),
    .result_o (alu_result)
  );

  reg_file i_reg_file (
    .clk (clk),
    .rst (rst),
    .rf  (rf_bus.rf)
  );

  mem_writeback i_mem_writeback (
    .dec_i        (dec),
    .pc_i         (pc),
    .alu_result_i (alu_result),
    .store_en_i   (store_en),
    .rf           (rf_bus.wb),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_rdata_i (dmem_rdata_i)
  );

endmodule

/* rtl/mem_writeback.sv */
`timescale 1ns/10ps

module mem_writeback import rv_pkg::*; (
  input  decoded_t   dec_i,
  input  word_t      pc_i,
  input  word_t      alu_result_i,
  input  logic       store_en_i,
  rf_if.wb           rf,
  output word_t      dmem_addr_o,
  output word_t      dmem_wdata_o,
  output logic [3:0] dmem_we_o,
  input  word_t      dmem_rdata_i
);

  logic [1:0]  offset;
  logic [3:0]  strobe;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  word_t       ld_value;

  assign offset      = alu_result_i[1:0];
  assign dmem_addr_o = {alu_result_i[XLEN-1:2], 2'b00};

  // replicate the store data so every lane carries it
  always_comb begin
    case (dec_i.funct3)
      F3_B: begin
        dmem_wdata_o = {4{rf.rs2_data[7:0]}};
        strobe       = 4'b0001 << offset;
      end
      F3_H: begin
        dmem_wdata_o = {2{rf.rs2_data[15:0]}};
        strobe       = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata_o = rf.rs2_data;
        strobe       = 4'b1111;
      end
    endcase
  end

  assign dmem_we_o = store_en_i ? strobe : 4'b0000;

  assign ld_byte = dmem_rdata_i[8*offset +: 8];
  assign ld_half = offset[1] ? dmem_rdata_i[31:16] : dmem_rdata_i[15:0];

  always_comb begin
    case (dec_i.funct3)
      F3_B:    ld_value = {{24{ld_byte[7]}}, ld_byte};
      F3_BU:   ld_value = {24'd0, ld_byte};
      F3_H:    ld_value = {{16{ld_half[15]}}, ld_half};
      F3_HU:   ld_value = {16'd0, ld_half};
      default: ld_value = dmem_rdata_i;
    endcase
  end

  always_comb begin
    case (dec_i.cls)
      CLS_LOAD:          rf.rd_wdata = ld_value;
      CLS_JAL, CLS_JALR: rf.rd_wdata = pc_i + 32'd4;
      default:           rf.rd_wdata = alu_result_i;
    endcase
  end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
  input logic clk,
  input logic rst,
  rf_if.rf    rf
);

  word_t regs [NUM_REGS];

  // x0 is never written, so it reads as zero after reset
  assign rf.rs1_data = regs[rf.rs1_addr];
  assign rf.rs2_data = regs[rf.rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.rd_we && rf.rd_addr != 5'd0) begin
      regs[rf.rd_addr] <= rf.rd_wdata;
    end
  end

endmodule

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu import rv_pkg::*; (
  input  decoded_t dec_i,
  input  word_t    pc_i,
  rf_if.src        rf,
  output word_t    result_o
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  always_comb begin
    case (dec_i.opa_sel)
      OPA_PC:   op_a = pc_i;
      OPA_ZERO: op_a = '0;
      default:  op_a = rf.rs1_data;
    endcase
    case (dec_i.opb_sel)
      OPB_RS2:  op_b = rf.rs2_data;
      OPB_FOUR: op_b = 32'd4;
      default:  op_b = dec_i.imm;
    endcase
  end

  assign shamt = op_b[4:0];

  // also yields rs1 + imm as the effective address for loads and stores
  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:  result_o = op_a + op_b;
      ALU_SUB:  result_o = op_a - op_b;
      ALU_SLL:  result_o = op_a << shamt;
      ALU_SLT:  result_o = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result_o = {31'd0, op_a < op_b};
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SRL:  result_o = op_a >> shamt;
      ALU_SRA:  result_o = $signed(op_a) >>> shamt;
      ALU_OR:   result_o = op_a | op_b;
      default:  result_o = op_a & op_b;
    endcase
  end

endmodule

/* rtl/insn_decoder.sv */
`timescale 1ns/10ps

module insn_decoder import rv_pkg::*; (
  input  word_t    insn_i,
  output decoded_t dec_o,
  rf_if.dec        rf
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD:  alu_sel = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  alu_sel = ALU_SLL;
      F3_SLT:  alu_sel = ALU_SLT;
      F3_SLTU: alu_sel = ALU_SLTU;
      F3_XOR:  alu_sel = ALU_XOR;
      F3_SR:   alu_sel = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                  insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                  insn_i[30:21], 1'b0};
  assign imm_u = {insn_i[31:12], 12'd0};

  assign rf.rs1_addr = insn_i[19:15];
  assign rf.rs2_addr = insn_i[24:20];
  assign rf.rd_addr  = insn_i[11:7];

  always_comb begin
    // unknown encodings fall through as system and halt the core
    dec_o.cls     = CLS_SYSTEM;
    dec_o.rd      = insn_i[11:7];
    dec_o.rs1     = insn_i[19:15];
    dec_o.rs2     = insn_i[24:20];
    dec_o.funct3  = funct3;
    dec_o.alu_op  = ALU_ADD;
    dec_o.opa_sel = OPA_RS1;
    dec_o.opb_sel = OPB_IMM;
    dec_o.imm     = imm_i;
    dec_o.rd_we   = 1'b0;
    case (opcode)
      OP_LUI: begin
        dec_o.cls     = CLS_ALU;
        dec_o.opa_sel = OPA_ZERO;
        dec_o.imm     = imm_u;
        dec_o.rd_we   = 1'b1;
      end
      OP_AUIPC: begin
        dec_o.cls     = CLS_ALU;
        dec_o.opa_sel = OPA_PC;
        dec_o.imm     = imm_u;
        dec_o.rd_we   = 1'b1;
      end
      OP_JAL: begin
        dec_o.cls     = CLS_JAL;
        dec_o.opa_sel = OPA_PC;
        dec_o.opb_sel = OPB_FOUR;
        dec_o.imm     = imm_j;
        dec_o.rd_we   = 1'b1;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          dec_o.cls   = CLS_JALR;
          dec_o.rd_we = 1'b1;
        end
      end
      OP_BRANCH: begin
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          dec_o.cls     = CLS_BRANCH;
          dec_o.alu_op  = ALU_SUB;
          dec_o.opb_sel = OPB_RS2;
          dec_o.imm     = imm_b;
        end
      end
      OP_LOAD: begin
        if (funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) begin
          dec_o.cls   = CLS_LOAD;
          dec_o.rd_we = 1'b1;
        end
      end
      OP_STORE: begin
        if (funct3 inside {F3_B, F3_H, F3_W}) begin
          dec_o.cls = CLS_STORE;
          dec_o.imm = imm_s;
        end
      end
      OP_IMM: begin
        // shift immediates keep funct7 in the upper imm bits
        if ((funct3 == F3_SLL && funct7 != 7'd0) ||
            (funct3 == F3_SR && funct7 != 7'd0 && funct7 != ALT_FUNCT7)) begin
          dec_o.cls = CLS_SYSTEM;
        end else begin
          dec_o.cls    = CLS_ALU;
          dec_o.alu_op = alu_sel(funct3, (funct3 == F3_SR) && (funct7 == ALT_FUNCT7));
          dec_o.rd_we  = 1'b1;
        end
      end
      OP_OP: begin
        if (funct7 == 7'd0 ||
            (funct7 == ALT_FUNCT7 && (funct3 == F3_ADD || funct3 == F3_SR))) begin
          dec_o.cls     = CLS_ALU;
          dec_o.alu_op  = alu_sel(funct3, funct7 == ALT_FUNCT7);
          dec_o.opb_sel = OPB_RS2;
          dec_o.rd_we   = 1'b1;
        end
      end
      OP_SYSTEM: dec_o.cls = CLS_SYSTEM;
      default:   dec_o.cls = CLS_SYSTEM;
    endcase
  end

endmodule

/* rtl/pc_unit.sv */
`timescale 1ns/10ps

module pc_unit import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     pc_en_i,
  input  decoded_t dec_i,
  rf_if.src        rf,
  input  word_t    alu_result_i,
  output word_t    pc_o
);

  logic  taken;
  word_t next_pc;

  always_comb begin
    case (dec_i.funct3)
      F3_BEQ:  taken = (rf.rs1_data == rf.rs2_data);
      F3_BNE:  taken = (rf.rs1_data != rf.rs2_data);
      F3_BLT:  taken = ($signed(rf.rs1_data) < $signed(rf.rs2_data));
      F3_BGE:  taken = ($signed(rf.rs1_data) >= $signed(rf.rs2_data));
      F3_BLTU: taken = (rf.rs1_data < rf.rs2_data);
      F3_BGEU: taken = (rf.rs1_data >= rf.rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec_i.cls == CLS_JALR) begin
      // target is rs1 + imm from the alu, lsb cleared
      next_pc = {alu_result_i[XLEN-1:1], 1'b0};
    end else if (dec_i.cls == CLS_JAL || (dec_i.cls == CLS_BRANCH && taken)) begin
      next_pc = pc_o + dec_i.imm;
    end else begin
      next_pc = pc_o + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= '0;
    end else if (pc_en_i) begin
      pc_o <= next_pc;
    end
  end

endmodule

/* rtl/core_fsm.sv */
`timescale 1ns/10ps

module core_fsm import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  decoded_t dec_i,
  rf_if.ctl        rf,
  output logic     imem_rd_o,
  output logic     dmem_rd_o,
  output logic     store_en_o,
  output logic     pc_en_o,
  output logic     halt_o,
  output word_t    instret_o
);

  core_state_t state_q;
  core_state_t state_d;
  logic        retire;

  always_comb begin
    state_d   = state_q;
    imem_rd_o = 1'b0;
    dmem_rd_o = 1'b0;
    retire    = 1'b0;
    case (state_q)
      FETCH: begin
        imem_rd_o = 1'b1;
        state_d   = EXECUTE;
      end
      EXECUTE: begin
        case (dec_i.cls)
          CLS_LOAD: begin
            dmem_rd_o = 1'b1;
            state_d   = LOAD_WAIT;
          end
          // ecall and anything not decoded stop the core
          CLS_SYSTEM: state_d = HALTED;
          default: begin
            retire  = 1'b1;
            state_d = FETCH;
          end
        endcase
      end
      LOAD_WAIT: begin
        retire  = 1'b1;
        state_d = FETCH;
      end
      HALTED:  state_d = HALTED;
      default: state_d = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= FETCH;
      instret_o <= '0;
    end else begin
      state_q <= state_d;
      if (retire) begin
        instret_o <= instret_o + 1'b1;
      end
    end
  end

  // stores drive strobes only in their execute cycle
  assign store_en_o = (state_q == EXECUTE) && (dec_i.cls == CLS_STORE);
  assign pc_en_o    = retire;
  assign rf.rd_we   = retire && dec_i.rd_we;
  assign halt_o     = (state_q == HALTED);

endmodule

/* rtl/rf_if.sv */
`timescale 1ns/10ps

interface rf_if import rv_pkg::*; ();

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd_addr;
  word_t     rd_wdata;
  logic      rd_we;

  modport rf  (input rs1_addr, rs2_addr, rd_addr, rd_wdata, rd_we,
               output rs1_data, rs2_data);
  modport dec (output rs1_addr, rs2_addr, rd_addr);
  modport wb  (output rd_wdata, input rs2_data);
  modport ctl (output rd_we);
  // operand reads for alu and branch compare
  modport src (input rs1_data, rs2_data);

endinterface

/* rtl/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load/store sizes
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // integer op selection
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // selects sub and sra
  localparam logic [6:0] ALT_FUNCT7 = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_t;
  typedef enum logic [1:0] {OPB_RS2, OPB_IMM, OPB_FOUR} opb_sel_t;

  typedef enum logic [2:0] {
    CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_SYSTEM
  } insn_class_t;

  typedef struct packed {
    insn_class_t cls;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  funct3;
    alu_op_t     alu_op;
    opa_sel_t    opa_sel;
    opb_sel_t    opb_sel;
    word_t       imm;
    logic        rd_we;
  } decoded_t;

  typedef enum logic [1:0] {FETCH, EXECUTE, LOAD_WAIT, HALTED} core_state_t;

endpackage
